// File: source/fp_pkg.sv
package fp_pkg;

	////////////////////
	// binary32 layout
	////////////////////

	// Exponent and stored fraction widths
	localparam int EXP_W = 8;
	localparam int MAN_W = 23;

	// Largest exponent field of a finite number
	localparam logic [EXP_W-1:0] EXP_MAX = 8'd254;

	////////////////////
	// Datapath widths
	////////////////////

	// Significand with the hidden one
	localparam int SIG_W = MAN_W + 1;

	// Guard, round and sticky below the significand
	localparam int EXT_W = SIG_W + 3;

	// Requested operation
	typedef enum logic
	{
		OP_ADD = 1'b0,
		OP_SUB = 1'b1
	} fp_op_e;

endpackage

// File: source/fp_exp_compare.sv
`timescale 1ns/1ps

module fp_exp_compare
(
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        in_valid,
	input  fp_pkg::fp_op_e              op,
	input  logic [31:0]                 a,
	input  logic [31:0]                 b,
	output logic                        s1_valid,
	output logic                        s1_sign_a,
	output logic                        s1_sign_b,
	output logic                        s1_eff_sub,
	output logic                        s1_a_exp_greater,
	output logic                        s1_b_exp_greater,
	output logic [fp_pkg::EXP_W-1:0]    s1_exp_diff,
	output logic [fp_pkg::EXP_W-1:0]    s1_exp_big,
	output logic [fp_pkg::SIG_W-1:0]    s1_sig_a,
	output logic [fp_pkg::SIG_W-1:0]    s1_sig_b
);

	logic [fp_pkg::EXP_W-1:0] exp_a;
	logic [fp_pkg::EXP_W-1:0] exp_b;
	logic                     a_gt;
	logic                     b_gt;
	logic                     sign_b_op;

	// Field extraction
	assign exp_a = a[fp_pkg::EXP_W+fp_pkg::MAN_W-1:fp_pkg::MAN_W];
	assign exp_b = b[fp_pkg::EXP_W+fp_pkg::MAN_W-1:fp_pkg::MAN_W];

	assign a_gt = (exp_a > exp_b);
	assign b_gt = (exp_b > exp_a);

	// Subtraction is an addition with b negated
	assign sign_b_op = b[31] ^ (op == fp_pkg::OP_SUB);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		s1_sign_a        <= a[31];
		s1_sign_b        <= sign_b_op;
		s1_eff_sub       <= a[31] ^ sign_b_op;
		s1_a_exp_greater <= a_gt;
		s1_b_exp_greater <= b_gt;
		s1_exp_diff      <= a_gt ? (exp_a - exp_b) : (exp_b - exp_a);
		s1_exp_big       <= b_gt ? exp_b : exp_a;
		// Zero exponent field flushes the operand to zero
		s1_sig_a         <= (exp_a == '0) ? '0 : {1'b1, a[fp_pkg::MAN_W-1:0]};
		s1_sig_b         <= (exp_b == '0) ? '0 : {1'b1, b[fp_pkg::MAN_W-1:0]};
	end

	// Alignment shifts at most one operand
	a_flags_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
		s1_valid |-> !(s1_a_exp_greater && s1_b_exp_greater));

endmodule

// File: source/fp_align_shift.sv
`timescale 1ns/1ps

module fp_align_shift
(
	input  logic                        s1_a_exp_greater,
	input  logic                        s1_b_exp_greater,
	input  logic [fp_pkg::EXP_W-1:0]    s1_exp_diff,
	input  logic [fp_pkg::SIG_W-1:0]    s1_sig_a,
	input  logic [fp_pkg::SIG_W-1:0]    s1_sig_b,
	output logic [fp_pkg::EXT_W-1:0]    al_a,
	output logic [fp_pkg::EXT_W-1:0]    al_b
);

	// Right shift with every lost bit ORed into bit 0
	function automatic logic [fp_pkg::EXT_W-1:0] shift_sticky
	(
		input logic [fp_pkg::EXT_W-1:0] value,
		input logic [fp_pkg::EXP_W-1:0] amount
	);
		int unsigned              shamt;
		logic [fp_pkg::EXT_W-1:0] kept;
		logic                     lost;
		shamt = (amount > fp_pkg::EXT_W) ? fp_pkg::EXT_W : amount;
		kept  = value >> shamt;
		lost  = ((kept << shamt) != value);
		return {kept[fp_pkg::EXT_W-1:1], kept[0] | lost};
	endfunction

	logic [fp_pkg::EXT_W-1:0] ext_a;
	logic [fp_pkg::EXT_W-1:0] ext_b;

	// Guard, round and sticky start out clear
	assign ext_a = {s1_sig_a, 3'b000};
	assign ext_b = {s1_sig_b, 3'b000};

	// Only the operand with the smaller exponent moves
	assign al_a = s1_b_exp_greater ? shift_sticky(ext_a, s1_exp_diff) : ext_a;
	assign al_b = s1_a_exp_greater ? shift_sticky(ext_b, s1_exp_diff) : ext_b;

endmodule

// File: source/fp_sign_decide.sv
`timescale 1ns/1ps

module fp_sign_decide
(
	input  logic s1_eff_sub,
	input  logic s1_sign_a,
	input  logic s1_sign_b,
	input  logic s1_a_exp_greater,
	input  logic s1_b_exp_greater,
	input  logic mant_borrow,
	output logic res_sign
);

	logic [2:0] sign_cases;

	assign sign_cases = {s1_eff_sub, s1_a_exp_greater, s1_b_exp_greater};

	always_comb
	begin
		casez (sign_cases)
			// Effective addition keeps the common sign
			3'b0??:  res_sign = s1_sign_a;

			// a dominates by exponent
			3'b110:  res_sign = s1_sign_a;
			3'b111:  res_sign = s1_sign_a;

			// b dominates by exponent
			3'b101:  res_sign = s1_sign_b;

			// Same exponent, the mantissa difference decides
			3'b100:  res_sign = mant_borrow ? s1_sign_b : s1_sign_a;

			default: res_sign = s1_sign_a;
		endcase
	end

endmodule

// File: source/fp_mant_addsub.sv
`timescale 1ns/1ps

module fp_mant_addsub
(
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        s1_valid,
	input  logic                        s1_eff_sub,
	input  logic [fp_pkg::EXP_W-1:0]    s1_exp_big,
	input  logic [fp_pkg::EXT_W-1:0]    al_a,
	input  logic [fp_pkg::EXT_W-1:0]    al_b,
	input  logic                        res_sign,
	output logic                        mant_borrow,
	output logic                        s2_valid,
	output logic                        s2_sign,
	output logic [fp_pkg::EXT_W:0]      s2_mag,
	output logic [fp_pkg::EXP_W-1:0]    s2_exp
);

	logic [fp_pkg::EXT_W+1:0] opa;
	logic [fp_pkg::EXT_W+1:0] opb;
	logic [fp_pkg::EXT_W+1:0] raw;
	logic [fp_pkg::EXT_W+1:0] neg;

	////////////////////
	// Two's complement add
	////////////////////

	// Two spare bits on top, one for the carry and one for the sign
	assign opa = {2'b00, al_a};
	assign opb = {2'b00, al_b};

	assign raw = s1_eff_sub ? (opa + ~opb + 1'b1) : (opa + opb);
	assign neg = ~raw + 1'b1;

	// Top bit set only when b exceeded a
	assign mant_borrow = raw[fp_pkg::EXT_W+1];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			s2_valid <= 1'b0;
		else
			s2_valid <= s1_valid;
	end

	always_ff @(posedge clk)
	begin
		s2_sign <= res_sign;
		s2_exp  <= s1_exp_big;
		s2_mag  <= mant_borrow ? neg[fp_pkg::EXT_W:0] : raw[fp_pkg::EXT_W:0];
	end

	////////////////////
	// Checks
	////////////////////

	// The sum of two magnitudes never reaches the sign bit
	a_no_borrow_on_add: assert property (@(posedge clk) disable iff (!arst_n)
		(s1_valid && !s1_eff_sub) |-> !mant_borrow);

endmodule

// File: source/fp_normalize.sv
`timescale 1ns/1ps

module fp_normalize
(
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        s2_valid,
	input  logic                        s2_sign,
	input  logic [fp_pkg::EXT_W:0]      s2_mag,
	input  logic [fp_pkg::EXP_W-1:0]    s2_exp,
	output logic                        out_valid,
	output logic [31:0]                 result
);

	// Zeros above the leading one, all ones counted for a zero value
	function automatic logic [4:0] count_lz
	(
		input logic [fp_pkg::EXT_W-1:0] value
	);
		logic [4:0] n;
		logic       found;
		n     = '0;
		found = 1'b0;
		for (int i = fp_pkg::EXT_W - 1; i >= 0; i--)
		begin
			if (!found)
			begin
				if (value[i])
					found = 1'b1;
				else
					n = n + 1'b1;
			end
		end
		return n;
	endfunction

	logic                            carry;
	logic [4:0]                      lz;
	logic [fp_pkg::EXT_W-1:0]        norm;
	logic signed [fp_pkg::EXP_W+1:0] exp_adj;
	logic [31:0]                     next_result;

	assign carry = s2_mag[fp_pkg::EXT_W];
	assign lz    = count_lz(s2_mag[fp_pkg::EXT_W-1:0]);

	////////////////////
	// Normalize
	////////////////////

	always_comb
	begin
		if (carry)
		begin
			// Bit shifted out on the right joins the sticky
			norm    = {s2_mag[fp_pkg::EXT_W:2], s2_mag[1] | s2_mag[0]};
			exp_adj = $signed({2'b00, s2_exp}) + 10'sd1;
		end
		else
		begin
			norm    = s2_mag[fp_pkg::EXT_W-1:0] << lz;
			exp_adj = $signed({2'b00, s2_exp}) - $signed({5'b00000, lz});
		end
	end

	// Guard, round and sticky are dropped, which is round toward zero
	always_comb
	begin
		if (s2_mag == '0)
			next_result = 32'h0000_0000;
		else if (exp_adj > $signed({2'b00, fp_pkg::EXP_MAX}))
			next_result = {s2_sign, fp_pkg::EXP_MAX, {fp_pkg::MAN_W{1'b1}}};
		else if (exp_adj <= 0)
			next_result = {s2_sign, 31'h0000_0000};
		else
			next_result = {s2_sign, exp_adj[fp_pkg::EXP_W-1:0],
				norm[fp_pkg::EXT_W-2:3]};
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			out_valid <= 1'b0;
			result    <= '0;
		end
		else
		begin
			out_valid <= s2_valid;
			if (s2_valid)
				result <= next_result;
		end
	end

	// Infinity and NaN encodings never leave the adder
	a_no_special_exp: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> (result[30:23] != 8'hff));

endmodule

// File: source/fp_adder_top.sv
`timescale 1ns/1ps

module fp_adder_top
(
	input  logic           clk,
	input  logic           arst_n,
	input  logic           in_valid,
	input  fp_pkg::fp_op_e op,
	input  logic [31:0]    a,
	input  logic [31:0]    b,
	output logic           out_valid,
	output logic [31:0]    result
);

	// Stage 1
	logic                     s1_valid;
	logic                     s1_sign_a;
	logic                     s1_sign_b;
	logic                     s1_eff_sub;
	logic                     s1_a_exp_greater;
	logic                     s1_b_exp_greater;
	logic [fp_pkg::EXP_W-1:0] s1_exp_diff;
	logic [fp_pkg::EXP_W-1:0] s1_exp_big;
	logic [fp_pkg::SIG_W-1:0] s1_sig_a;
	logic [fp_pkg::SIG_W-1:0] s1_sig_b;

	// Stage 2
	logic [fp_pkg::EXT_W-1:0] al_a;
	logic [fp_pkg::EXT_W-1:0] al_b;
	logic                     mant_borrow;
	logic                     res_sign;
	logic                     s2_valid;
	logic                     s2_sign;
	logic [fp_pkg::EXT_W:0]   s2_mag;
	logic [fp_pkg::EXP_W-1:0] s2_exp;

	fp_exp_compare u_exp_compare
	(
		.clk              (clk),
		.arst_n           (arst_n),
		.in_valid         (in_valid),
		.op               (op),
		.a                (a),
		.b                (b),
		.s1_valid         (s1_valid),
		.s1_sign_a        (s1_sign_a),
		.s1_sign_b        (s1_sign_b),
		.s1_eff_sub       (s1_eff_sub),
		.s1_a_exp_greater (s1_a_exp_greater),
		.s1_b_exp_greater (s1_b_exp_greater),
		.s1_exp_diff      (s1_exp_diff),
		.s1_exp_big       (s1_exp_big),
		.s1_sig_a         (s1_sig_a),
		.s1_sig_b         (s1_sig_b)
	);

	fp_align_shift u_align_shift
	(
		.s1_a_exp_greater (s1_a_exp_greater),
		.s1_b_exp_greater (s1_b_exp_greater),
		.s1_exp_diff      (s1_exp_diff),
		.s1_sig_a         (s1_sig_a),
		.s1_sig_b         (s1_sig_b),
		.al_a             (al_a),
		.al_b             (al_b)
	);

	fp_sign_decide u_sign_decide
	(
		.s1_eff_sub       (s1_eff_sub),
		.s1_sign_a        (s1_sign_a),
		.s1_sign_b        (s1_sign_b),
		.s1_a_exp_greater (s1_a_exp_greater),
		.s1_b_exp_greater (s1_b_exp_greater),
		.mant_borrow      (mant_borrow),
		.res_sign         (res_sign)
	);

	fp_mant_addsub u_mant_addsub
	(
		.clk         (clk),
		.arst_n      (arst_n),
		.s1_valid    (s1_valid),
		.s1_eff_sub  (s1_eff_sub),
		.s1_exp_big  (s1_exp_big),
		.al_a        (al_a),
		.al_b        (al_b),
		.res_sign    (res_sign),
		.mant_borrow (mant_borrow),
		.s2_valid    (s2_valid),
		.s2_sign     (s2_sign),
		.s2_mag      (s2_mag),
		.s2_exp      (s2_exp)
	);

	fp_normalize u_normalize
	(
		.clk       (clk),
		.arst_n    (arst_n),
		.s2_valid  (s2_valid),
		.s2_sign   (s2_sign),
		.s2_mag    (s2_mag),
		.s2_exp    (s2_exp),
		.out_valid (out_valid),
		.result    (result)
	);

endmodule

// File: testbench/fp_adder_tb.sv
`timescale 1ns/1ps

module fp_adder_tb;

	localparam logic [31:0] SEED        = 32'he164f475;
	localparam int          BURST_OPS   = 200;
	localparam int          DRAIN_LIMIT = 50;

	logic           clk;
	logic           arst_n;
	logic           in_valid;
	fp_pkg::fp_op_e op;
	logic [31:0]    a;
	logic [31:0]    b;
	logic           out_valid;
	logic [31:0]    result;

	// Expected results and the clock edge that drove each operation
	logic [31:0]    exp_q[$];
	int             edge_q[$];
	int             edge_count = 0;
	int             issued     = 0;
	int             checked    = 0;
	int             errors     = 0;

	fp_adder_top dut0
	(
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.op        (op),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.result    (result)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
		edge_count <= edge_count + 1;

	////////////////////
	// Reference model
	////////////////////

	// Exact sum in a wide fixed point, then truncated toward zero
	function automatic logic [31:0] expected_sum
	(
		input logic [31:0]    x_in,
		input logic [31:0]    y_in,
		input fp_pkg::fp_op_e opc
	);
		int           ex;
		int           ey;
		int           top;
		int           e_res;
		logic         sx;
		logic         sy;
		logic         sr;
		logic [287:0] x;
		logic [287:0] y;
		logic [287:0] mag;
		logic [287:0] kept;
		ex = int'(x_in[30:23]);
		ey = int'(y_in[30:23]);
		sx = x_in[31];
		sy = y_in[31] ^ (opc == fp_pkg::OP_SUB);
		// Zero exponent field means zero
		x = (ex == 0) ? '0 : {264'd0, 1'b1, x_in[22:0]} << 256;
		y = (ey == 0) ? '0 : {264'd0, 1'b1, y_in[22:0]} << 256;
		// Wide enough that no bit is lost for any exponent gap
		if (ex >= ey)
			y = y >> (ex - ey);
		else
			x = x >> (ey - ex);
		if (sx == sy)
		begin
			mag = x + y;
			sr  = sx;
		end
		else if (x >= y)
		begin
			mag = x - y;
			sr  = sx;
		end
		else
		begin
			mag = y - x;
			sr  = sy;
		end
		top = -1;
		for (int i = 0; i < 288; i++)
			if (mag[i])
				top = i;
		if (top < 0)
			return 32'h0000_0000;
		// Bit 279 holds the hidden one at the larger exponent
		e_res = ((ex >= ey) ? ex : ey) + top - 279;
		kept  = mag >> (top - 23);
		if (e_res > 254)
			return {sr, 8'hfe, 23'h7f_ffff};
		else if (e_res <= 0)
			return {sr, 31'd0};
		else
			return {sr, e_res[7:0], kept[22:0]};
	endfunction

	function automatic logic [31:0] pack_fp(input logic s, input int e, input logic [22:0] f);
		return {s, e[7:0], f};
	endfunction

	// Exponent field stays below 255
	function automatic logic [31:0] random_operand(input int lo, input int hi);
		logic [31:0] r;
		logic [31:0] e;
		r = $urandom();
		e = $urandom_range(hi, lo);
		return {r[31], e[7:0], r[22:0]};
	endfunction

	task automatic report_mismatch
	(
		input string       name,
		input logic [31:0] want,
		input logic [31:0] got
	);
		errors++;
		$display("FAIL %s expected %h actual %h", name, want, got);
	endtask

	task automatic report_problem(input string msg);
		errors++;
		$display("ERROR: %s", msg);
	endtask

	task automatic issue_op
	(
		input fp_pkg::fp_op_e opc,
		input logic [31:0]    x_in,
		input logic [31:0]    y_in
	);
		@(posedge clk);
		in_valid <= 1'b1;
		op       <= opc;
		a        <= x_in;
		b        <= y_in;
	endtask

	// Stop issuing and let the pipeline empty
	task automatic finish_group;
		int waited;
		@(posedge clk);
		in_valid <= 1'b0;
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0)
		begin
			report_problem("timeout, out_valid never came for an issued operation");
			exp_q.delete();
			edge_q.delete();
		end
	endtask

	////////////////////
	// Compare
	////////////////////

	always @(negedge clk)
	begin
		logic [31:0] want;
		int          launched;
		if (arst_n && out_valid)
		begin
			assert (exp_q.size() != 0)
			else report_problem("out_valid was high with no operation outstanding");
			if (exp_q.size() != 0)
			begin
				want     = exp_q.pop_front();
				launched = edge_q.pop_front();
				checked++;
				assert (result == want) else report_mismatch("result", want, result);
				assert (edge_count == launched + 3)
				else report_problem("out_valid did not come 3 cycles after in_valid");
			end
		end
		// Driven on the rising edge just passed
		if (arst_n && in_valid)
		begin
			exp_q.push_back(expected_sum(a, b, op));
			edge_q.push_back(edge_count);
			issued++;
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	initial
	begin
		logic [31:0] r;
		logic [31:0] ra;
		logic [31:0] rb;
		int          eb;
		clk      = 1'b0;
		arst_n   = 1'b0;
		in_valid = 1'b0;
		op       = fp_pkg::OP_ADD;
		a        = '0;
		b        = '0;
		void'($urandom(SEED));
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;

		// Quiet outputs before any operation
		repeat (4)
		begin
			@(negedge clk);
			assert (!out_valid) else report_mismatch("out_valid", 32'd0, {31'd0, out_valid});
			assert (result == '0) else report_mismatch("result", 32'd0, result);
		end

		// Effective additions over many exponent gaps
		for (int d = 0; d <= 40; d++)
		begin
			r = $urandom();
			issue_op(fp_pkg::OP_ADD, pack_fp(r[0], 140, r[22:0]), pack_fp(r[0], 140 - d, r[31:9]));
			issue_op(fp_pkg::OP_SUB, pack_fp(r[1], 100 - d, r[30:8]), pack_fp(!r[1], 100, r[24:2]));
		end
		finish_group();

		// Effective subtractions in both exponent orders
		for (int d = 0; d <= 30; d++)
		begin
			r = $urandom();
			issue_op(fp_pkg::OP_SUB, pack_fp(r[0], 120, r[22:0]), pack_fp(r[0], 120 - d, r[31:9]));
			issue_op(fp_pkg::OP_ADD, pack_fp(r[1], 90 - d, r[30:8]), pack_fp(!r[1], 90, r[24:2]));
		end
		// Equal exponents, either mantissa larger
		issue_op(fp_pkg::OP_SUB, pack_fp(1'b0, 127, 23'h40_0000), pack_fp(1'b0, 127, 23'h10_0000));
		issue_op(fp_pkg::OP_SUB, pack_fp(1'b0, 127, 23'h10_0000), pack_fp(1'b0, 127, 23'h40_0000));
		issue_op(fp_pkg::OP_ADD, pack_fp(1'b1, 127, 23'h10_0000), pack_fp(1'b0, 127, 23'h40_0000));
		// Heavy cancellation
		issue_op(fp_pkg::OP_SUB, pack_fp(1'b0, 100, 23'h00_0001), pack_fp(1'b0, 100, 23'h00_0000));
		issue_op(fp_pkg::OP_SUB, pack_fp(1'b1, 101, 23'h00_0000), pack_fp(1'b1, 100, 23'h7f_ffff));
		issue_op(fp_pkg::OP_SUB, 32'h4049_0fdb, 32'h4049_0fdb);
		issue_op(fp_pkg::OP_ADD, 32'hc049_0fdb, 32'h4049_0fdb);
		finish_group();

		// Zeros, subnormals, underflow and overflow
		issue_op(fp_pkg::OP_ADD, 32'h0000_0000, 32'h3f80_0000);
		issue_op(fp_pkg::OP_SUB, 32'h0040_0000, 32'h3f80_0000);
		issue_op(fp_pkg::OP_ADD, 32'h8000_0000, 32'h8000_0000);
		issue_op(fp_pkg::OP_SUB, 32'h007f_ffff, 32'h0000_0001);
		issue_op(fp_pkg::OP_SUB, pack_fp(1'b0, 1, 23'h00_0001), pack_fp(1'b0, 1, 23'h00_0000));
		issue_op(fp_pkg::OP_SUB, pack_fp(1'b1, 2, 23'h00_0000), pack_fp(1'b1, 1, 23'h7f_fff0));
		issue_op(fp_pkg::OP_ADD, 32'h7f7f_ffff, 32'h7f7f_ffff);
		issue_op(fp_pkg::OP_SUB, 32'hff7f_ffff, 32'h7f00_0000);
		finish_group();

		// Back-to-back random traffic
		for (int i = 0; i < BURST_OPS; i++)
		begin
			r  = $urandom();
			ra = random_operand(1, 254);
			eb = int'(ra[30:23]) - int'(r[3:0]);
			if (eb < 0)
				eb = 0;
			rb = r[4] ? random_operand(0, 254) : pack_fp(r[5], eb, r[31:9]);
			issue_op(fp_pkg::fp_op_e'(r[6]), ra, rb);
		end
		finish_group();

		assert (checked == issued) else report_problem("not every operation produced a result");
		$display("Results checked: %0d, errors: %0d", checked, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: sim.f
source/fp_pkg.sv
source/fp_exp_compare.sv
source/fp_align_shift.sv
source/fp_sign_decide.sv
source/fp_mant_addsub.sv
source/fp_normalize.sv
source/fp_adder_top.sv
testbench/fp_adder_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the floating-point adder testbench with Verilator.
# The run passes only if the log holds the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f --top-module fp_adder_tb -Mdir obj_dir \
	&& ./obj_dir/Vfp_adder_tb > sim.log 2>&1 \
	; cat sim.log 2>/dev/null \
	; grep -qx "Done: no errors" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
